// ==== src/mips_consts.svh ====
// ==================================================================
// mips_core constants
// widths, reset fetch address and memory depths
// ==================================================================
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define WORD_W      32              // data and instruction width
`define REG_ADDR_W  5               // gpr and cp0 address field
`define RESET_PC    32'h0000_0000   // first fetch after reset

// data memory depth in words
`define DMEM_WORDS  64
`define CP0_REGS    16              // implemented cp0 registers

`endif

// ==== src/mips_isa_pkg.sv ====
// ==================================================================
// mips_isa_pkg
// instruction-set encodings for the reduced MIPS subset
// ==================================================================
package mips_isa_pkg;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,   // r-type, see funct
        OP_ADDIU   = 6'h09,
        OP_COP0    = 6'h10,   // see cop0_op_e in rs field
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function code of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25
    } funct_e;

    // rs field of a COP0 instruction
    typedef enum logic [4:0] {
        CP0_MF = 5'h00,   // mfc0 rt, rd
        CP0_MT = 5'h04    // mtc0 rt, rd
    } cop0_op_e;

endpackage

// ==== src/mips_pipe_pkg.sv ====
// ==================================================================
// mips_pipe_pkg
// pipeline control types shared by decode, forwarding and the core
// ==================================================================
package mips_pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B     // mtc0 data passes through
    } alu_op_e;

    // writeback value source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_CP0
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_REG,        // value read in decode
        FWD_MEM_STAGE,
        FWD_WB_STAGE
    } fwd_sel_e;

endpackage

// ==== src/instr_decode.sv ====
// ==================================================================
// instr_decode
// decode-stage instruction to control levels and register addresses
// ==================================================================
`timescale 1ns/1ps
`include "mips_consts.svh"

module instr_decode import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic [`WORD_W-1:0]     instr,
    output logic [`REG_ADDR_W-1:0] rs,
    output logic [`REG_ADDR_W-1:0] rt,
    output logic [`REG_ADDR_W-1:0] rd_dest,
    output logic                   rs_read,
    output logic                   rt_read,
    output logic [`WORD_W-1:0]     imm,
    output alu_op_e                alu_op,
    output wb_sel_e                wb_sel,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic                   reg_write,
    output logic                   cp0_write
);
    opcode_e  opcode;
    funct_e   funct;
    cop0_op_e cop0_op;

    assign opcode  = opcode_e'(instr[31:26]);
    assign funct   = funct_e'(instr[5:0]);
    assign cop0_op = cop0_op_e'(instr[25:21]);   // rs field doubles as cop0 op

    assign rs  = instr[25:21];
    assign rt  = instr[20:16];
    assign imm = {{16{instr[15]}}, instr[15:0]};   // sign extend

    always_comb begin
        // nop unless proven otherwise
        rd_dest   = '0;
        rs_read   = 1'b0;
        rt_read   = 1'b0;
        alu_op    = ALU_ADD;
        wb_sel    = WB_ALU;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        cp0_write = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                if (funct inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR}) begin
                    rd_dest   = instr[15:11];   // r-type writes rd
                    rs_read   = 1'b1;
                    rt_read   = 1'b1;
                    reg_write = 1'b1;
                end
                case (funct)
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_ADDIU: begin
                rd_dest   = rt;
                rs_read   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LW: begin
                rd_dest   = rt;
                rs_read   = 1'b1;   // base
                wb_sel    = WB_MEM;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OP_SW: begin
                rs_read   = 1'b1;
                rt_read   = 1'b1;   // store data
                mem_write = 1'b1;
            end
            OP_COP0: begin
                if (cop0_op == CP0_MF) begin
                    rd_dest   = rt;
                    wb_sel    = WB_CP0;
                    reg_write = 1'b1;
                end else if (cop0_op == CP0_MT) begin
                    rt_read   = 1'b1;
                    alu_op    = ALU_PASS_B;   // rt value rides to memory stage
                    cp0_write = 1'b1;
                end
            end
            default: ;   // unknown opcode stays a nop
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
// ==================================================================
// reg_file
// 32x32 gpr, two read ports, one write port with same-cycle bypass
// ==================================================================
`timescale 1ns/1ps
`include "mips_consts.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] ra,
    input  logic [`REG_ADDR_W-1:0] rb,
    output logic [`WORD_W-1:0]     qa,
    output logic [`WORD_W-1:0]     qb,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] wa,
    input  logic [`WORD_W-1:0]     wd
);
    localparam int NREGS = 1 << `REG_ADDR_W;

    logic [`WORD_W-1:0] regs [0:NREGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin   // r0 stays zero
            regs[wa] <= wd;
        end
    end

    // writeback lands in the same cycle as the decode read
    assign qa = (we && wa == ra && ra != '0) ? wd : regs[ra];
    assign qb = (we && wa == rb && rb != '0) ? wd : regs[rb];

endmodule

// ==== src/cp0_regs.sv ====
// ==================================================================
// cp0_regs
// coprocessor 0 bank, read in decode, written from the memory stage
// ==================================================================
`timescale 1ns/1ps
`include "mips_consts.svh"

module cp0_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] raddr,
    output logic [`WORD_W-1:0]     rdata,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`WORD_W-1:0]     wdata
);
    localparam int IDX_W = $clog2(`CP0_REGS);

    logic [`WORD_W-1:0] bank [0:`CP0_REGS-1];
    logic               rd_hit;
    logic               wr_hit;

    assign rd_hit = raddr < `REG_ADDR_W'(`CP0_REGS);
    assign wr_hit = waddr < `REG_ADDR_W'(`CP0_REGS);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CP0_REGS; i++) begin
                bank[i] <= '0;
            end
        end else if (we && wr_hit) begin
            bank[waddr[IDX_W-1:0]] <= wdata;
        end
    end

    // no write bypass here, mfc0 waits in decode instead
    assign rdata = rd_hit ? bank[raddr[IDX_W-1:0]] : '0;

endmodule

// ==== src/forward_unit.sv ====
// ==================================================================
// forward_unit
// picks the newest producer of each execute operand
// ==================================================================
`timescale 1ns/1ps
`include "mips_consts.svh"

module forward_unit import mips_pipe_pkg::*; (
    input  logic [`REG_ADDR_W-1:0] exe_rs,
    input  logic [`REG_ADDR_W-1:0] exe_rt,
    input  logic [`REG_ADDR_W-1:0] mem_dest,
    input  logic                   mem_reg_write,
    input  logic [`REG_ADDR_W-1:0] wb_dest,
    input  logic                   wb_reg_write,
    output fwd_sel_e               fwd_a,
    output fwd_sel_e               fwd_b
);
    // memory stage is younger, so it is checked first
    function automatic fwd_sel_e pick(input logic [`REG_ADDR_W-1:0] src);
        if (mem_reg_write && mem_dest != '0 && mem_dest == src) begin
            return FWD_MEM_STAGE;
        end else if (wb_reg_write && wb_dest != '0 && wb_dest == src) begin
            return FWD_WB_STAGE;
        end
        return FWD_REG;   // r0 or no pending writer
    endfunction

    assign fwd_a = pick(exe_rs);
    assign fwd_b = pick(exe_rt);

endmodule

// ==== src/data_hazard.sv ====
// ==================================================================
// data_hazard
// stall and flush levels for load-use and mtc0/mfc0 conflicts
// ==================================================================
`timescale 1ns/1ps
`include "mips_consts.svh"

module data_hazard import mips_isa_pkg::*; (
    input  logic [`WORD_W-1:0] id_instr,
    input  logic               rs_read,
    input  logic               rt_read,
    input  logic [`WORD_W-1:0] exe_instr,
    input  logic [`WORD_W-1:0] mem_instr,
    output logic               pc_wr,
    output logic               id_wr,
    output logic               exe_wr,
    output logic               exe_flush,
    output logic               mem_flush
);
    logic load_use;
    logic exe_mtc0;
    logic mem_mtc0;
    logic id_mfc0;

    function automatic logic is_cop0(input logic [`WORD_W-1:0] w, input cop0_op_e op);
        return w[31:26] == OP_COP0 && w[25:21] == op;
    endfunction

    // loaded register is the rt field of the lw in execute
    assign load_use = exe_instr[31:26] == OP_LW &&
                      ((rs_read && id_instr[25:21] == exe_instr[20:16]) ||
                       (rt_read && id_instr[20:16] == exe_instr[20:16]));

    assign exe_mtc0 = is_cop0(exe_instr, CP0_MT);
    assign mem_mtc0 = is_cop0(mem_instr, CP0_MT);
    assign id_mfc0  = is_cop0(id_instr, CP0_MF);

    always_comb begin
        if (load_use || (exe_mtc0 && id_mfc0)) begin
            pc_wr     = 1'b0;   // hold fetch and decode
            id_wr     = 1'b0;
            exe_wr    = 1'b1;
            exe_flush = 1'b1;   // bubble into execute
            mem_flush = 1'b0;
        end else if (mem_mtc0 && id_mfc0) begin
            // cp0 write lands at end of this cycle
            pc_wr     = 1'b0;
            id_wr     = 1'b0;
            exe_wr    = 1'b0;   // execute keeps its instruction
            exe_flush = 1'b0;
            mem_flush = 1'b1;
        end else begin
            pc_wr     = 1'b1;
            id_wr     = 1'b1;
            exe_wr    = 1'b1;
            exe_flush = 1'b0;
            mem_flush = 1'b0;
        end
    end

endmodule

// ==== src/mips_core.sv ====
// ==================================================================
// mips_core
// five-stage integer pipeline with forwarding and hazard stalls
// ==================================================================
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_core import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    output logic [`WORD_W-1:0]     inst_addr,
    input  logic [`WORD_W-1:0]     inst_data,
    output logic                   wb_en,
    output logic [`REG_ADDR_W-1:0] wb_reg,
    output logic [`WORD_W-1:0]     wb_data
);
    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    logic [`WORD_W-1:0]     pc;
    logic [`WORD_W-1:0]     id_instr;   // IF/ID
    logic [`REG_ADDR_W-1:0] id_rs, id_rt, id_dest;
    logic                   id_rs_read, id_rt_read;
    logic [`WORD_W-1:0]     id_imm, id_qa, id_qb, id_cp0;
    alu_op_e                id_alu_op;
    wb_sel_e                id_wb_sel;
    logic                   id_mem_read, id_mem_write, id_reg_write, id_cp0_write;
    logic                   id_use_imm;
    logic                   pc_wr, id_wr, exe_wr, exe_flush, mem_flush;
    // ID/EXE
    logic [`WORD_W-1:0]     exe_instr, exe_a, exe_b, exe_imm, exe_cp0;
    logic [`REG_ADDR_W-1:0] exe_dest;
    alu_op_e                exe_alu_op;
    wb_sel_e                exe_wb_sel;
    logic                   exe_mem_write, exe_reg_write, exe_cp0_write, exe_use_imm;
    fwd_sel_e               fwd_a, fwd_b;
    logic [`WORD_W-1:0]     op_a, op_b, alu_b, alu_out, exe_result;
    // EX/MEM
    logic [`WORD_W-1:0]     mem_instr, mem_result, mem_store, mem_out;
    logic [`REG_ADDR_W-1:0] mem_dest;
    wb_sel_e                mem_wb_sel;
    logic                   mem_mem_write, mem_reg_write, mem_cp0_write;
    logic [`WORD_W-1:0]     dmem [0:`DMEM_WORDS-1];
    // MEM/WB
    logic [`REG_ADDR_W-1:0] wb_dest;
    logic [`WORD_W-1:0]     wb_val;
    logic                   wb_reg_write;

    // fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= `RESET_PC;
            id_instr <= '0;
        end else begin
            if (pc_wr) pc <= pc + `WORD_W'(4);
            if (id_wr) id_instr <= inst_data;   // testbench answers same cycle
        end
    end
    assign inst_addr = pc;

    // decode
    instr_decode u_dec (
        .instr(id_instr), .rs(id_rs), .rt(id_rt), .rd_dest(id_dest),
        .rs_read(id_rs_read), .rt_read(id_rt_read), .imm(id_imm),
        .alu_op(id_alu_op), .wb_sel(id_wb_sel), .mem_read(id_mem_read),
        .mem_write(id_mem_write), .reg_write(id_reg_write), .cp0_write(id_cp0_write)
    );
    reg_file u_rf (
        .clk(clk), .rst(rst), .ra(id_rs), .rb(id_rt), .qa(id_qa), .qb(id_qb),
        .we(wb_en), .wa(wb_dest), .wd(wb_val)
    );
    cp0_regs u_cp0 (
        .clk(clk), .rst(rst), .raddr(id_instr[15:11]), .rdata(id_cp0),
        .we(mem_cp0_write), .waddr(mem_instr[15:11]), .wdata(mem_result)
    );
    data_hazard u_hazard (
        .id_instr(id_instr), .rs_read(id_rs_read), .rt_read(id_rt_read),
        .exe_instr(exe_instr), .mem_instr(mem_instr), .pc_wr(pc_wr), .id_wr(id_wr),
        .exe_wr(exe_wr), .exe_flush(exe_flush), .mem_flush(mem_flush)
    );
    assign id_use_imm = id_mem_read || id_mem_write || id_instr[31:26] == OP_ADDIU;

    always_ff @(posedge clk) begin
        if (rst || exe_flush) begin
            exe_instr     <= '0;   // bubble
            exe_alu_op    <= ALU_ADD;
            exe_wb_sel    <= WB_ALU;
            exe_mem_write <= 1'b0;
            exe_reg_write <= 1'b0;
            exe_cp0_write <= 1'b0;
            exe_use_imm   <= 1'b0;
        end else if (exe_wr) begin
            exe_instr     <= id_instr;
            exe_alu_op    <= id_alu_op;
            exe_wb_sel    <= id_wb_sel;
            exe_mem_write <= id_mem_write;
            exe_reg_write <= id_reg_write;
            exe_cp0_write <= id_cp0_write;
            exe_use_imm   <= id_use_imm;
        end
        if (exe_wr) begin
            exe_a    <= id_qa;
            exe_b    <= id_qb;
            exe_imm  <= id_imm;
            exe_cp0  <= id_cp0;
            exe_dest <= id_dest;
        end else begin
            // held in execute, keep forwarded operands before producer retires
            exe_a <= op_a;
            exe_b <= op_b;
        end
    end

    // execute
    forward_unit u_fwd (
        .exe_rs(exe_instr[25:21]), .exe_rt(exe_instr[20:16]),
        .mem_dest(mem_dest), .mem_reg_write(mem_reg_write),
        .wb_dest(wb_dest), .wb_reg_write(wb_reg_write), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    function automatic logic [`WORD_W-1:0] fwd_mux(input fwd_sel_e sel,
                                                   input logic [`WORD_W-1:0] reg_val);
        case (sel)
            FWD_MEM_STAGE: return mem_result;
            FWD_WB_STAGE:  return wb_val;
            default:       return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, exe_a);
    assign op_b  = fwd_mux(fwd_b, exe_b);
    assign alu_b = exe_use_imm ? exe_imm : op_b;

    always_comb begin
        case (exe_alu_op)
            ALU_SUB:    alu_out = op_a - alu_b;
            ALU_AND:    alu_out = op_a & alu_b;
            ALU_OR:     alu_out = op_a | alu_b;
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = op_a + alu_b;   // addu, addiu, address
        endcase
    end
    assign exe_result = (exe_wb_sel == WB_CP0) ? exe_cp0 : alu_out;

    always_ff @(posedge clk) begin
        if (rst || mem_flush) begin
            mem_instr     <= '0;
            mem_wb_sel    <= WB_ALU;
            mem_mem_write <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_cp0_write <= 1'b0;
        end else begin
            mem_instr     <= exe_instr;
            mem_wb_sel    <= exe_wb_sel;
            mem_mem_write <= exe_mem_write;
            mem_reg_write <= exe_reg_write;
            mem_cp0_write <= exe_cp0_write;
        end
        mem_result <= exe_result;
        mem_store  <= op_b;   // forwarded rt for sw
        mem_dest   <= exe_dest;
    end

    // memory, word addressed, async read
    always_ff @(posedge clk) begin
        if (mem_mem_write) dmem[mem_result[DMEM_AW+1:2]] <= mem_store;
    end
    assign mem_out = (mem_wb_sel == WB_MEM) ? dmem[mem_result[DMEM_AW+1:2]] : mem_result;

    always_ff @(posedge clk) begin
        if (rst) wb_reg_write <= 1'b0;
        else     wb_reg_write <= mem_reg_write;
        wb_dest <= mem_dest;
        wb_val  <= mem_out;
    end

    // writeback, r0 writes are dropped here
    assign wb_en   = wb_reg_write && wb_dest != '0;
    assign wb_reg  = wb_dest;
    assign wb_data = wb_val;

endmodule

// ==== verif/mips_core_assert.sv ====
// ==================================================================
// mips_core_assert
// hazard level and writeback properties, bound into mips_core
// ==================================================================
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_core_assert (
    input logic                   clk,
    input logic                   rst,
    input logic                   pc_wr,       // data_hazard outputs
    input logic                   id_wr,
    input logic                   exe_flush,
    input logic                   mem_flush,
    input logic                   wb_en,
    input logic [`REG_ADDR_W-1:0] wb_reg
);
    // only one bubble source per cycle
    flush_excl: assert property (@(posedge clk) disable iff (rst)
        !(exe_flush && mem_flush))
        else $error("exe_flush and mem_flush high together");

    // a held pc always holds IF/ID too
    hold_order: assert property (@(posedge clk) disable iff (rst) !pc_wr |-> !id_wr)
        else $error("id_wr high while pc_wr low");

    wb_after_rst: assert property (@(posedge clk) rst |=> !wb_en)
        else $error("wb_en high in the cycle after reset");

    wb_nonzero: assert property (@(posedge clk) disable iff (rst) wb_en |-> wb_reg != '0)
        else $error("writeback to r0 on wb_en");

endmodule

// pc_wr and friends are the nets u_hazard drives inside the core
bind mips_core mips_core_assert u_checks (
    .clk(clk), .rst(rst), .pc_wr(pc_wr), .id_wr(id_wr),
    .exe_flush(exe_flush), .mem_flush(mem_flush), .wb_en(wb_en), .wb_reg(wb_reg)
);

// ==== verif/mips_core_tb.sv ====
// ==================================================================
// mips_core_tb
// per-test program table, instruction answers and writeback checks
// ==================================================================
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_core_tb import mips_isa_pkg::*; ();
    localparam int MAX_ROWS   = 40;
    localparam int NUM_TESTS  = 5;
    localparam int WB_TIMEOUT = 20;   // cycles allowed per writeback

    logic                   clk = 1'b0;
    logic                   rst;
    logic [`WORD_W-1:0]     inst_addr;
    logic [`WORD_W-1:0]     inst_data;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_reg;
    logic [`WORD_W-1:0]     wb_data;

    // program table, one row per instruction
    int          row_test [0:MAX_ROWS-1];
    logic [31:0] row_word [0:MAX_ROWS-1];
    bit          row_wr   [0:MAX_ROWS-1];   // expects a writeback
    logic [4:0]  row_reg  [0:MAX_ROWS-1];
    logic [31:0] row_val  [0:MAX_ROWS-1];
    int          hold_exp [1:NUM_TESTS];    // stall cycles seen on inst_addr
    int          num_rows;
    int          cur_base;
    int          cur_len;
    int          holds;
    int          errors;
    int          tests_failed;
    logic [31:0] last_addr;

    mips_core UUT (
        .clk(clk), .rst(rst), .inst_addr(inst_addr), .inst_data(inst_data),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    always #20 clk = ~clk;   // 40 ns period

    function automatic logic [31:0] rtype_word(input funct_e fn, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(input opcode_e op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // mfc0/mtc0 rt, rd
    function automatic logic [31:0] cop0_word(input cop0_op_e op, input logic [4:0] rt,
                                              input logic [4:0] rd);
        return {OP_COP0, op, rt, rd, 11'd0};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // nop once the pc runs past the test's rows
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr[31:2]);
        if (idx < cur_len) return row_word[cur_base + idx];
        return 32'd0;
    endfunction

    task automatic add_row(input int test, input logic [31:0] word, input bit wr,
                           input logic [4:0] rd, input logic [31:0] val);
        row_test[num_rows] = test;
        row_word[num_rows] = word;
        row_wr[num_rows]   = wr;
        row_reg[num_rows]  = rd;
        row_val[num_rows]  = val;
        num_rows++;
    endtask

    task automatic build_table();
        logic [31:0] seed;
        logic [31:0] sum;
        logic [15:0] imm;
        // 1: alu chain, deps at distance 1 and 2
        add_row(1, itype_word(OP_ADDIU, 5'd0, 5'd1, 16'h005a), 1'b1, 5'd1, 32'h0000_005a);
        add_row(1, itype_word(OP_ADDIU, 5'd1, 5'd2, 16'h0033), 1'b1, 5'd2, 32'h0000_008d);
        add_row(1, rtype_word(FN_ADDU, 5'd1, 5'd2, 5'd3), 1'b1, 5'd3, 32'h0000_00e7);
        add_row(1, rtype_word(FN_SUBU, 5'd1, 5'd3, 5'd4), 1'b1, 5'd4, 32'hffff_ff73);
        add_row(1, rtype_word(FN_AND, 5'd4, 5'd3, 5'd5), 1'b1, 5'd5, 32'h0000_0063);
        add_row(1, rtype_word(FN_OR, 5'd5, 5'd1, 5'd6), 1'b1, 5'd6, 32'h0000_007b);
        add_row(1, itype_word(OP_ADDIU, 5'd6, 5'd7, 16'hfff0), 1'b1, 5'd7, 32'h0000_006b);
        hold_exp[1] = 0;
        // 2: sw/lw round trip, then load-use
        add_row(2, itype_word(OP_ADDIU, 5'd0, 5'd1, 16'h1234), 1'b1, 5'd1, 32'h0000_1234);
        add_row(2, itype_word(OP_ADDIU, 5'd0, 5'd2, 16'h0010), 1'b1, 5'd2, 32'h0000_0010);
        add_row(2, itype_word(OP_SW, 5'd2, 5'd1, 16'h0004), 1'b0, 5'd0, 32'd0);
        add_row(2, itype_word(OP_LW, 5'd2, 5'd3, 16'h0004), 1'b1, 5'd3, 32'h0000_1234);
        add_row(2, rtype_word(FN_ADDU, 5'd3, 5'd1, 5'd4), 1'b1, 5'd4, 32'h0000_2468);
        hold_exp[2] = 1;
        // 3: mtc0 right before mfc0
        add_row(3, itype_word(OP_ADDIU, 5'd0, 5'd1, 16'h0abc), 1'b1, 5'd1, 32'h0000_0abc);
        add_row(3, cop0_word(CP0_MT, 5'd1, 5'd12), 1'b0, 5'd0, 32'd0);
        add_row(3, cop0_word(CP0_MF, 5'd2, 5'd12), 1'b1, 5'd2, 32'h0000_0abc);
        hold_exp[3] = 2;
        // 4: one instruction in between
        add_row(4, itype_word(OP_ADDIU, 5'd0, 5'd1, 16'h0555), 1'b1, 5'd1, 32'h0000_0555);
        add_row(4, cop0_word(CP0_MT, 5'd1, 5'd3), 1'b0, 5'd0, 32'd0);
        add_row(4, itype_word(OP_ADDIU, 5'd0, 5'd5, 16'h0009), 1'b1, 5'd5, 32'h0000_0009);
        add_row(4, cop0_word(CP0_MF, 5'd6, 5'd3), 1'b1, 5'd6, 32'h0000_0555);
        hold_exp[4] = 1;
        // 5: r0 targets stay silent, random addiu accumulation
        seed = 32'd49;
        sum  = 32'd0;
        add_row(5, itype_word(OP_ADDIU, 5'd0, 5'd0, 16'h0055), 1'b0, 5'd0, 32'd0);
        add_row(5, rtype_word(FN_ADDU, 5'd1, 5'd2, 5'd0), 1'b0, 5'd0, 32'd0);
        for (int k = 0; k < 6; k++) begin
            seed = lcg_next(seed);
            imm  = seed[30:15];
            sum  = sum + {{16{imm[15]}}, imm};   // addiu sign extends
            add_row(5, itype_word(OP_ADDIU, (k == 0) ? 5'd0 : 5'd8, 5'd8, imm),
                    1'b1, 5'd8, sum);
        end
        add_row(5, itype_word(OP_ADDIU, 5'd8, 5'd0, 16'h1111), 1'b0, 5'd0, 32'd0);
        add_row(5, rtype_word(FN_ADDU, 5'd8, 5'd0, 5'd9), 1'b1, 5'd9, sum);   // r0 must not forward
        hold_exp[5] = 0;
    endtask

    // one cycle, answer the fetch and count pc holds
    task automatic next_cycle();
        @(negedge clk);
        if (!rst) begin
            if (inst_addr == last_addr) holds++;
            last_addr = inst_addr;
        end
        inst_data = fetch_word(inst_addr);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        int first_err;
        int seen;
        int waited;
        first_err = errors;
        seen      = 0;
        cur_base  = -1;
        cur_len   = 0;
        for (int r = 0; r < num_rows; r++) begin
            if (row_test[r] == t) begin
                if (cur_base < 0) cur_base = r;
                cur_len++;
            end
        end
        rst = 1'b1;
        repeat (3) next_cycle();
        rst       = 1'b0;
        holds     = 0;
        last_addr = inst_addr;
        for (int r = cur_base; r < cur_base + cur_len; r++) begin
            if (row_wr[r]) begin
                waited = 0;
                next_cycle();
                while (!wb_en && waited < WB_TIMEOUT) begin
                    next_cycle();
                    waited++;
                end
                if (!wb_en) begin
                    $display("test %0d: row %0d never retired within %0d cycles",
                             t, r - cur_base, WB_TIMEOUT);
                    errors++;
                    break;
                end
                check_value("wb_reg", 32'(wb_reg), 32'(row_reg[r]));
                check_value("wb_data", wb_data, row_val[r]);
                seen++;
            end
        end
        // trailing nops, nothing more may retire
        repeat (8) begin
            next_cycle();
            if (wb_en) begin
                $display("test %0d: unexpected writeback to r%0d at %0t", t, wb_reg, $time);
                errors++;
            end
        end
        check_value("inst_addr hold cycles", holds, hold_exp[t]);
        if (errors != first_err) tests_failed++;
        $display("test %0d %s: %0d writebacks, %0d hold cycles", t,
                 (errors == first_err) ? "passed" : "failed", seen, holds);
    endtask

    initial begin
        rst          = 1'b1;
        inst_data    = 32'd0;
        num_rows     = 0;
        cur_base     = 0;
        cur_len      = 0;
        holds        = 0;
        errors       = 0;
        tests_failed = 0;
        last_addr    = `RESET_PC;
        build_table();
        for (int t = 1; t <= NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== mips_core.f ====
+incdir+src
src/mips_isa_pkg.sv
src/mips_pipe_pkg.sv
src/instr_decode.sv
src/reg_file.sv
src/cp0_regs.sv
src/forward_unit.sv
src/data_hazard.sv
src/mips_core.sv
verif/mips_core_assert.sv
verif/mips_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build mips_core_tb with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f mips_core.f \
    --top-module mips_core_tb -o mips_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mips_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
